/* list.f */
+incdir+verilog
verilog/cache_pkg.sv
verilog/request_decode.sv
verilog/cache_store.sv
verilog/coherence_execute.sv
verilog/response_result.sv
verilog/moesi_cache_top.sv
dv/cache_checker.sv
dv/tb_moesi_cache.sv

/* Bender.yml */
package:
  name: moesi_cache

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cache_pkg.sv
      - verilog/request_decode.sv
      - verilog/cache_store.sv
      - verilog/coherence_execute.sv
      - verilog/response_result.sv
      - verilog/moesi_cache_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/cache_checker.sv
      - dv/tb_moesi_cache.sv

/* dv/tb_moesi_cache.sv */
`include "cache_params.svh"

module tb_moesi_cache
  import cache_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_TXN     = 400;
  localparam int CYCLE_LIMIT = NUM_TXN * 20;  // worst miss is about 12 cycles
  localparam int MEM_WORDS   = 1 << `ADDR_WIDTH;

  logic  clk, rst_n;
  logic  cpu_read_req, cpu_write_req, inv_req, gets_req;
  addr_t cpu_read_addr, cpu_write_addr, inv_addr, gets_addr, cache_req_addr;
  data_t cpu_write_data, cpu_read_data, wb_data, owned_data;
  logic  cpu_read_ack, cpu_write_ack, inv_ack, gets_ack;
  logic  read_s, read_ex, write_back;
  tag_t  wb_tag;
  logic  read_s_ack = 1'b0;      // directory model outputs
  logic  read_ex_ack = 1'b0;
  logic  shared = 1'b0;
  data_t mem_data = '0;

  // expected values for the checker
  op_e   exp_op = op_none;
  addr_t exp_addr = '0;
  logic  exp_rs = 1'b0, exp_rex = 1'b0, exp_wb = 1'b0;
  tag_t  exp_wb_tag = '0;
  data_t exp_wb_data = '0, exp_data = '0;
  int    value_errs, proto_errs;

  // reference model, directory memory and prediction scratch
  moesi_e m_state [`CACHE_LINES];
  tag_t   m_tag   [`CACHE_LINES];
  data_t  m_data  [`CACHE_LINES];
  data_t  backing [MEM_WORDS];
  logic   p_rs, p_rex, p_wb;
  tag_t   p_wb_tag;
  data_t  p_wb_data, p_data;
  logic [15:0] lfsr;
  int     txn_delay = 1;         // directory answer delay of the current miss
  logic   txn_shared = 1'b0;
  int     dir_cnt = 0;
  int     cycle_cnt;

  moesi_cache_top i_dut (
    .clk, .rst_n,
    .cpu_read_req, .cpu_read_addr, .cpu_read_ack, .cpu_read_data,
    .cpu_write_req, .cpu_write_addr, .cpu_write_data, .cpu_write_ack,
    .read_s, .read_ex, .cache_req_addr, .write_back, .wb_tag, .wb_data,
    .read_s_ack, .read_ex_ack, .mem_data, .shared,
    .inv_req, .inv_addr, .inv_ack, .gets_req, .gets_addr, .gets_ack, .owned_data
  );

  cache_checker i_checker (
    .clk, .rst_n, .cpu_read_req, .cpu_write_req, .inv_req, .gets_req,
    .cpu_read_ack, .cpu_read_data, .cpu_write_ack,
    .read_s, .read_ex, .cache_req_addr, .write_back, .wb_tag, .wb_data,
    .read_s_ack, .read_ex_ack, .inv_ack, .gets_ack, .owned_data,
    .exp_op, .exp_addr, .exp_rs, .exp_rex, .exp_wb, .exp_wb_tag, .exp_wb_data, .exp_data,
    .value_errs, .proto_errs
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;     // 8 ns period
  end

  // 16-bit Galois LFSR, one step per bit handed out
  function automatic logic [15:0] take_bits(input int count);
    logic [15:0] bits;
    logic        lsb;
    bits = '0;
    for (int k = 0; k < count; k++) begin
      lsb  = lfsr[0];
      lfsr = lfsr >> 1;
      if (lsb) lfsr = lfsr ^ 16'hb400;     // taps 16 14 13 11
      bits = {bits[14:0], lsb};
    end
    return bits;
  endfunction

  // few indices so that tags keep colliding
  function automatic index_t pool_index(input logic [1:0] k);
    case (k)
      2'd0:    return 7'h00;
      2'd1:    return 7'h2a;
      2'd2:    return 7'h55;
      default: return 7'h7f;
    endcase
  endfunction

  // ------------------------------------------------------------------------
  // reference model, MOESI rules applied to one transaction
  // ------------------------------------------------------------------------
  function automatic void predict(input op_e kind, input addr_t addr, input data_t wdata,
                                  input logic shr);
    index_t idx;
    tag_t   tg;
    moesi_e st;
    logic   hit;
    idx = addr[`INDEX_WIDTH-1:0];
    tg  = addr[`ADDR_WIDTH-1 -: `TAG_WIDTH];
    st  = m_state[idx];
    hit = (st != line_i) && (m_tag[idx] == tg);
    p_rs      = 1'b0;
    p_rex     = 1'b0;
    p_wb      = 1'b0;
    p_wb_tag  = '0;
    p_wb_data = '0;
    p_data    = '0;
    if (((kind == op_cpu_read) || (kind == op_cpu_write)) && (st != line_i) && !hit) begin
      p_wb      = 1'b1;                      // any valid victim goes back
      p_wb_tag  = m_tag[idx];
      p_wb_data = m_data[idx];
      backing[{m_tag[idx], idx}] = m_data[idx];
    end
    case (kind)
      op_cpu_read: begin
        if (!hit) begin
          p_rs         = 1'b1;
          m_state[idx] = shr ? line_s : line_e;
          m_tag[idx]   = tg;
          m_data[idx]  = backing[addr];
        end
        p_data = m_data[idx];
      end
      op_cpu_write: begin
        p_rex        = !(hit && ((st == line_e) || (st == line_m)));
        m_state[idx] = line_m;
        m_tag[idx]   = tg;
        m_data[idx]  = wdata;
      end
      op_dir_inv: begin
        if (hit) begin
          if (st != line_s) p_data = m_data[idx];   // e o m hand the byte back
          if ((st == line_o) || (st == line_m)) backing[addr] = m_data[idx];
          m_state[idx] = line_i;
        end
      end
      default: begin
        if (hit) begin
          if ((st == line_o) || (st == line_m)) p_data = m_data[idx];
          if (st == line_e) m_state[idx] = line_s;
          else if (st == line_m) m_state[idx] = line_o;
        end
      end
    endcase
  endfunction

  // directory model, answers read_s and read_ex after txn_delay cycles
  always @(posedge clk) begin
    if (!rst_n) begin
      read_s_ack  <= 1'b0;
      read_ex_ack <= 1'b0;
      dir_cnt     <= 0;
    end else if (read_s_ack || read_ex_ack) begin
      read_s_ack  <= 1'b0;                   // one cycle pulse
      read_ex_ack <= 1'b0;
      shared      <= 1'b0;
      mem_data    <= '0;
      dir_cnt     <= 0;
    end else if (read_s || read_ex) begin
      if (dir_cnt + 1 >= txn_delay) begin
        read_s_ack  <= read_s;
        read_ex_ack <= read_ex;
        mem_data    <= backing[cache_req_addr];
        shared      <= read_s && txn_shared;
      end else begin
        dir_cnt <= dir_cnt + 1;
      end
    end
  end

  // ------------------------------------------------------------------------
  // stimulus, one transaction at a time
  // ------------------------------------------------------------------------
  initial begin : stimulus
    op_e         kind;
    addr_t       addr;
    data_t       wdata;
    logic        shr;
    logic [15:0] sel, tag_pick;
    cpu_read_req   = 1'b0;
    cpu_write_req  = 1'b0;
    inv_req        = 1'b0;
    gets_req       = 1'b0;
    cpu_read_addr  = '0;
    cpu_write_addr = '0;
    cpu_write_data = '0;
    inv_addr       = '0;
    gets_addr      = '0;
    rst_n          = 1'b0;
    lfsr           = 16'd30894;
    for (int i = 0; i < MEM_WORDS; i++) begin
      backing[i] = 8'(i * 29) ^ 8'(i >> 8) ^ 8'h6c;   // all nine address bits matter
    end
    for (int i = 0; i < `CACHE_LINES; i++) begin
      m_state[i] = line_i;
      m_tag[i]   = '0;
      m_data[i]  = '0;
    end
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    repeat (3) @(posedge clk);
    for (int n = 0; n < NUM_TXN; n++) begin
      @(posedge clk);                        // idle gap between transactions
      sel = take_bits(3);
      case (sel[2:0])
        3'd0, 3'd1, 3'd2: kind = op_cpu_read;
        3'd3, 3'd4, 3'd5: kind = op_cpu_write;
        3'd6:             kind = op_dir_inv;
        default:          kind = op_dir_gets;
      endcase
      sel      = take_bits(2);
      tag_pick = take_bits(2);
      addr     = {tag_pick[1:0], pool_index(sel[1:0])};
      sel      = take_bits(8);
      wdata    = sel[7:0];
      sel      = take_bits(1);
      shr      = sel[0];
      sel      = take_bits(3);
      predict(kind, addr, wdata, shr);
      exp_op      <= kind;
      exp_addr    <= addr;
      exp_rs      <= p_rs;
      exp_rex     <= p_rex;
      exp_wb      <= p_wb;
      exp_wb_tag  <= p_wb_tag;
      exp_wb_data <= p_wb_data;
      exp_data    <= p_data;
      txn_delay   <= (sel % 6) + 1;          // 1 to 6 cycles
      txn_shared  <= shr;
      case (kind)
        op_cpu_read: begin
          cpu_read_addr <= addr;
          cpu_read_req  <= 1'b1;
        end
        op_cpu_write: begin
          cpu_write_addr <= addr;
          cpu_write_data <= wdata;
          cpu_write_req  <= 1'b1;
        end
        op_dir_inv: begin
          inv_addr <= addr;
          inv_req  <= 1'b1;
        end
        default: begin
          gets_addr <= addr;
          gets_req  <= 1'b1;
        end
      endcase
      do @(posedge clk);
      while ((cpu_read_ack | cpu_write_ack | inv_ack | gets_ack) !== 1'b1);
      cpu_read_req  <= 1'b0;                 // drop in the cycle after the ack
      cpu_write_req <= 1'b0;
      inv_req       <= 1'b0;
      gets_req      <= 1'b0;
    end
    repeat (4) @(posedge clk);
    $display("error counts: value %0d, protocol %0d", value_errs, proto_errs);
    if ((value_errs + proto_errs) == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: transactions did not finish within %0d cycles", CYCLE_LIMIT);
    $display("error counts: value %0d, protocol %0d", value_errs, proto_errs);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* dv/cache_checker.sv */
module cache_checker
  import cache_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  cpu_read_req,
  input  logic  cpu_write_req,
  input  logic  inv_req,
  input  logic  gets_req,
  input  logic  cpu_read_ack,
  input  data_t cpu_read_data,
  input  logic  cpu_write_ack,
  input  logic  read_s,
  input  logic  read_ex,
  input  addr_t cache_req_addr,
  input  logic  write_back,
  input  tag_t  wb_tag,
  input  data_t wb_data,
  input  logic  read_s_ack,
  input  logic  read_ex_ack,
  input  logic  inv_ack,
  input  logic  gets_ack,
  input  data_t owned_data,
  // expected behavior of the transaction in flight
  input  op_e   exp_op,
  input  addr_t exp_addr,
  input  logic  exp_rs,
  input  logic  exp_rex,
  input  logic  exp_wb,
  input  tag_t  exp_wb_tag,
  input  data_t exp_wb_data,
  input  data_t exp_data,
  output int    value_errs,
  output int    proto_errs
);

  timeunit 1ns;
  timeprecision 1ps;

  int   n_value = 0;
  int   n_proto = 0;
  int   cycles = 0;           // edges since the request was taken
  logic active = 1'b0;
  logic reset_seen = 1'b0;    // outputs are defined after one reset edge
  logic saw_rs, saw_rex, saw_wb;
  logic dir_ack_d = 1'b0;     // directory ack seen at the previous edge
  logic prev_dir_ack;
  logic any_req, any_ack;

  assign value_errs = n_value;
  assign proto_errs = n_proto;

  function automatic string txn_name();
    case (exp_op)
      op_cpu_read:  return exp_rs ? "read_miss" : "read_hit";
      op_cpu_write: return exp_rex ? "write_upgrade_or_miss" : "write_hit";
      op_dir_inv:   return "invalidate";
      op_dir_gets:  return "gets";
      default:      return "idle";
    endcase
  endfunction

  task automatic value_error(input string name, input string what,
                             input logic [15:0] exp, input logic [15:0] act);
    n_value++;
    $display("ERROR %s: %s expected %0h, actual %0h at %0t", name, what, exp, act, $time);
  endtask

  task automatic protocol_error(input string what);
    n_proto++;
    $display("protocol error at %0t: %s", $time, what);
  endtask

  // ------------------------------------------------------------------------
  // directory side requests while the transaction is open
  // ------------------------------------------------------------------------
  task automatic watch_requests();
    if ((read_s === 1'b1) && !saw_rs) begin
      saw_rs = 1'b1;
      if (!exp_rs) protocol_error("read_s raised for an access that needs no fill");
      else if (cache_req_addr !== exp_addr)
        value_error(txn_name(), "read_s address", exp_addr, cache_req_addr);
    end
    if ((read_ex === 1'b1) && !saw_rex) begin
      saw_rex = 1'b1;
      if (!exp_rex) protocol_error("read_ex raised for a write that owns the line");
      else if (cache_req_addr !== exp_addr)
        value_error(txn_name(), "read_ex address", exp_addr, cache_req_addr);
    end
    if ((write_back === 1'b1) && !saw_wb) begin
      saw_wb = 1'b1;
      if (!exp_wb) protocol_error("write_back raised without a valid victim");
      else begin
        if (wb_tag !== exp_wb_tag) value_error("eviction", "wb_tag", exp_wb_tag, wb_tag);
        if (wb_data !== exp_wb_data) value_error("eviction", "wb_data", exp_wb_data, wb_data);
      end
    end
  endtask

  // the ack edge, checks the returned byte and the path taken
  task automatic close_txn(input logic after_dir);
    int n_ack;
    n_ack = cpu_read_ack + cpu_write_ack + inv_ack + gets_ack;
    if (n_ack != 1) protocol_error("more than one ack pulsed at once");
    if (exp_rs && !saw_rs) protocol_error("read miss completed without read_s");
    if (exp_rex && !saw_rex) protocol_error("write completed without read_ex");
    if (exp_wb && !saw_wb) protocol_error("victim line evicted without write_back");
    if (exp_rs || exp_rex) begin
      if (!after_dir) protocol_error("cache ack came without a directory answer");
    end else if (cycles != 4) begin
      value_error(txn_name(), "ack latency", 16'd4, cycles[15:0]);   // fixed fast path
    end
    case (exp_op)
      op_cpu_read: begin
        if (cpu_read_ack !== 1'b1) protocol_error("read finished with a foreign ack");
        else if (cpu_read_data !== exp_data)
          value_error(txn_name(), "cpu_read_data", exp_data, cpu_read_data);
      end
      op_cpu_write: begin
        if (cpu_write_ack !== 1'b1) protocol_error("write finished with a foreign ack");
      end
      op_dir_inv: begin
        if (inv_ack !== 1'b1) protocol_error("invalidate finished with a foreign ack");
        else if (wb_data !== exp_data) value_error(txn_name(), "wb_data", exp_data, wb_data);
      end
      default: begin
        if (gets_ack !== 1'b1) protocol_error("gets finished with a foreign ack");
        else if (owned_data !== exp_data)
          value_error(txn_name(), "owned_data", exp_data, owned_data);
      end
    endcase
  endtask

  always @(posedge clk) begin
    any_req = cpu_read_req || cpu_write_req || inv_req || gets_req;
    any_ack = cpu_read_ack || cpu_write_ack || inv_ack || gets_ack;
    if (active) begin
      cycles++;
      watch_requests();
      prev_dir_ack = dir_ack_d;
      dir_ack_d    = read_s_ack || read_ex_ack;
      if (prev_dir_ack && !any_ack) protocol_error("cache ack did not follow the directory ack");
      if (any_ack) begin
        close_txn(prev_dir_ack);
        active = 1'b0;
      end
    end else if (reset_seen) begin
      if ({cpu_read_ack, cpu_write_ack, inv_ack, gets_ack, read_s, read_ex, write_back}
          !== 7'b0)
        protocol_error("ack or directory request high with no transaction in flight");
      if (rst_n && any_req) begin                   // taken at this very edge
        active    = 1'b1;
        cycles    = 0;
        saw_rs    = 1'b0;
        saw_rex   = 1'b0;
        saw_wb    = 1'b0;
        dir_ack_d = 1'b0;
      end
    end
    if (!rst_n) reset_seen = 1'b1;
  end

endmodule

/* verilog/moesi_cache_top.sv */
module moesi_cache_top
  import cache_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  // cpu side
  input  logic  cpu_read_req,
  input  addr_t cpu_read_addr,
  output logic  cpu_read_ack,
  output data_t cpu_read_data,
  input  logic  cpu_write_req,
  input  addr_t cpu_write_addr,
  input  data_t cpu_write_data,
  output logic  cpu_write_ack,
  // directory requests from the cache
  output logic  read_s,
  output logic  read_ex,
  output addr_t cache_req_addr,
  output logic  write_back,
  output tag_t  wb_tag,
  output data_t wb_data,
  input  logic  read_s_ack,
  input  logic  read_ex_ack,
  input  data_t mem_data,
  input  logic  shared,
  // directory requests to the cache
  input  logic  inv_req,
  input  addr_t inv_addr,
  output logic  inv_ack,
  input  logic  gets_req,
  input  addr_t gets_addr,
  output logic  gets_ack,
  output data_t owned_data
);

  logic   op_valid, op_done;
  op_e    op;
  addr_t  op_addr;
  index_t op_index, rd_index, wr_index;
  tag_t   op_tag, rd_tag, wr_tag;
  data_t  op_wdata, rd_data, wr_data;
  moesi_e rd_state, wr_state;
  logic   wr_en, wr_data_en;
  logic   done;
  op_e    done_op;
  data_t  done_rdata, done_wbdata, done_owned;

  assign op_done = done; // frees the decoder

  // ---------------------------------------------------------------------------
  // pipeline, decode -> store -> execute -> result
  // ---------------------------------------------------------------------------
  request_decode i_request_decode (
    .clk, .rst_n,
    .cpu_read_req, .cpu_read_addr,
    .cpu_write_req, .cpu_write_addr, .cpu_write_data,
    .inv_req, .inv_addr, .gets_req, .gets_addr,
    .op_done,
    .op_valid, .op, .op_addr, .op_index, .op_tag, .op_wdata,
    .rd_index
  );

  cache_store i_cache_store (
    .clk, .rst_n,
    .rd_index,
    .wr_en, .wr_index, .wr_state, .wr_tag, .wr_data, .wr_data_en,
    .rd_state, .rd_tag, .rd_data
  );

  coherence_execute i_coherence_execute (
    .clk, .rst_n,
    .op_valid, .op, .op_addr, .op_index, .op_tag, .op_wdata,
    .rd_state, .rd_tag, .rd_data,
    .read_s_ack, .read_ex_ack, .mem_data, .shared,
    .wr_en, .wr_index, .wr_state, .wr_tag, .wr_data, .wr_data_en,
    .read_s, .read_ex, .cache_req_addr, .write_back, .wb_tag,
    .done, .done_op, .done_rdata, .done_wbdata, .done_owned
  );

  response_result i_response_result (
    .clk, .rst_n,
    .done, .done_op, .done_rdata, .done_wbdata, .done_owned,
    .cpu_read_ack, .cpu_read_data, .cpu_write_ack,
    .inv_ack, .wb_data, .gets_ack, .owned_data
  );

endmodule

/* verilog/response_result.sv */
module response_result
  import cache_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  done,
  input  op_e   done_op,
  input  data_t done_rdata,
  input  data_t done_wbdata,
  input  data_t done_owned,
  output logic  cpu_read_ack,
  output data_t cpu_read_data,
  output logic  cpu_write_ack,
  output logic  inv_ack,
  output data_t wb_data,
  output logic  gets_ack,
  output data_t owned_data
);

  logic rd_done, wr_done, inv_done, gets_done;

  // steer the done pulse by transaction kind
  assign rd_done   = done && (done_op == op_cpu_read);
  assign wr_done   = done && (done_op == op_cpu_write);
  assign inv_done  = done && (done_op == op_dir_inv);
  assign gets_done = done && (done_op == op_dir_gets);

  // ---------------------------------------------------------------------------
  // ack pulses, one per completed op
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cpu_read_ack  <= 1'b0;
      cpu_write_ack <= 1'b0;
      inv_ack       <= 1'b0;
      gets_ack      <= 1'b0;
    end else begin
      cpu_read_ack  <= rd_done;      // done is single cycle, so are these
      cpu_write_ack <= wr_done;
      inv_ack       <= inv_done;
      gets_ack      <= gets_done;
    end
  end

  // return bytes, zero outside their ack
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cpu_read_data <= '0;
      owned_data    <= '0;
      wb_data       <= '0;
    end else begin
      cpu_read_data <= rd_done ? done_rdata : '0;
      owned_data    <= gets_done ? done_owned : '0;
      // execute keeps this nonzero only for inv done or a pending write-back
      wb_data       <= done_wbdata;
    end
  end

endmodule

/* verilog/coherence_execute.sv */
module coherence_execute
  import cache_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   op_valid,
  input  op_e    op,
  input  addr_t  op_addr,
  input  index_t op_index,
  input  tag_t   op_tag,
  input  data_t  op_wdata,
  input  moesi_e rd_state,
  input  tag_t   rd_tag,
  input  data_t  rd_data,
  input  logic   read_s_ack,
  input  logic   read_ex_ack,
  input  data_t  mem_data,
  input  logic   shared,
  output logic   wr_en,
  output index_t wr_index,
  output moesi_e wr_state,
  output tag_t   wr_tag,
  output data_t  wr_data,
  output logic   wr_data_en,
  output logic   read_s,
  output logic   read_ex,
  output addr_t  cache_req_addr,
  output logic   write_back,
  output tag_t   wb_tag,
  output logic   done,
  output op_e    done_op,
  output data_t  done_rdata,
  output data_t  done_wbdata,
  output data_t  done_owned
);

  typedef enum logic [1:0] {idle, lookup, wait_dir} fsm_e;

  fsm_e  state;
  logic  valid_line, hit, evict, write_ok, dir_done;
  logic  done_q;   // fast path completion
  data_t rdata_q;  // read hit byte
  data_t owned_q;  // gets data
  data_t wb_hold;  // victim or invalidate byte

  // ---------------------------------------------------------------------------
  // hit detection on the line read out of the store
  // ---------------------------------------------------------------------------
  assign valid_line = (rd_state != line_i);
  assign hit        = valid_line && (rd_tag == op_tag);
  assign evict      = valid_line && (rd_tag != op_tag) &&
                      ((op == op_cpu_read) || (op == op_cpu_write)); // dirty or clean victim
  assign write_ok   = hit && ((rd_state == line_e) || (rd_state == line_m)); // no dir needed
  assign dir_done   = (state == wait_dir) &&
                      ((read_s && read_s_ack) || (read_ex && read_ex_ack));

  // line update, MOESI next state
  always_comb begin
    wr_en      = 1'b0;
    wr_index   = op_index;
    wr_tag     = op_tag;
    wr_state   = rd_state;
    wr_data    = op_wdata;
    wr_data_en = 1'b0;
    if (dir_done) begin              // fill on the directory ack
      wr_en      = 1'b1;
      wr_data_en = 1'b1;
      if (read_s) begin
        wr_state = shared ? line_s : line_e;
        wr_data  = mem_data;
      end else begin
        wr_state = line_m;           // cpu byte wins over mem_data
      end
    end else if ((state == lookup) && hit) begin
      case (op)
        op_cpu_write: begin
          if (write_ok) begin        // e/m -> m, silent upgrade
            wr_en      = 1'b1;
            wr_state   = line_m;
            wr_data_en = 1'b1;
          end
        end
        op_dir_inv: begin
          wr_en    = 1'b1;
          wr_state = line_i;
        end
        op_dir_gets: begin
          wr_en = 1'b1;
          case (rd_state)
            line_e:  wr_state = line_s;
            line_m:  wr_state = line_o;
            default: wr_state = rd_state; // s and o stay
          endcase
        end
        default: wr_en = 1'b0;       // read hit, state unchanged
      endcase
    end
  end

  // ---------------------------------------------------------------------------
  // transaction FSM and directory requests
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= idle;
      read_s     <= 1'b0;
      read_ex    <= 1'b0;
      write_back <= 1'b0;
      done_q     <= 1'b0;
      wb_hold    <= '0;
    end else begin
      done_q <= 1'b0;
      case (state)
        idle: begin
          wb_hold <= '0;             // inv byte lives one cycle
          if (op_valid) state <= lookup;
        end
        lookup: begin
          write_back <= evict;       // rises with read_s/read_ex
          if (evict) wb_hold <= rd_data;
          case (op)
            op_cpu_read: begin
              if (hit) begin
                done_q <= 1'b1;
                state  <= idle;
              end else begin
                read_s <= 1'b1;
                state  <= wait_dir;
              end
            end
            op_cpu_write: begin
              if (write_ok) begin
                done_q <= 1'b1;
                state  <= idle;
              end else begin         // miss, or s/o upgrade
                read_ex <= 1'b1;
                state   <= wait_dir;
              end
            end
            op_dir_inv: begin
              done_q <= 1'b1;
              state  <= idle;
              if (hit && (rd_state != line_s)) wb_hold <= rd_data; // e, o, m
            end
            op_dir_gets: begin
              done_q <= 1'b1;
              state  <= idle;
            end
            default: state <= idle;
          endcase
        end
        wait_dir: begin
          if (dir_done) begin        // drop requests the cycle after ack
            read_s     <= 1'b0;
            read_ex    <= 1'b0;
            write_back <= 1'b0;
            wb_hold    <= '0;
            state      <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // payload captured in lookup
  always_ff @(posedge clk) begin
    if (state == lookup) begin
      rdata_q        <= rd_data;
      cache_req_addr <= op_addr;
      wb_tag         <= rd_tag;      // victim tag
      owned_q        <= (hit && ((rd_state == line_o) || (rd_state == line_m))) ?
                        rd_data : '0;
    end
  end

  // miss completion bypasses the done register so the ack follows the dir ack
  assign done        = done_q || dir_done;
  assign done_op     = op;           // decode holds op until the next capture
  assign done_rdata  = dir_done ? mem_data : rdata_q;
  assign done_wbdata = ((state == lookup) && evict) ? rd_data :
                       (dir_done ? '0 : wb_hold);
  assign done_owned  = owned_q;

endmodule

/* verilog/cache_store.sv */
`include "cache_params.svh"

module cache_store
  import cache_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  index_t rd_index,
  input  logic   wr_en,
  input  index_t wr_index,
  input  moesi_e wr_state,
  input  tag_t   wr_tag,
  input  data_t  wr_data,
  input  logic   wr_data_en,
  output moesi_e rd_state,
  output tag_t   rd_tag,
  output data_t  rd_data
);

  moesi_e state_mem [`CACHE_LINES]; // per line coherence state
  tag_t   tag_mem   [`CACHE_LINES];
  data_t  data_mem  [`CACHE_LINES];

  // write port, state and tag always, data on demand
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `CACHE_LINES; i++) begin
        state_mem[i] <= line_i;          // whole cache empty
        tag_mem[i]   <= '0;
        data_mem[i]  <= '0;
      end
    end else if (wr_en) begin
      state_mem[wr_index] <= wr_state;
      tag_mem[wr_index]   <= wr_tag;
      if (wr_data_en) begin
        data_mem[wr_index] <= wr_data;   // inv and gets keep the byte
      end
    end
  end

  // registered read, one cycle after rd_index
  always_ff @(posedge clk) begin
    rd_state <= state_mem[rd_index];
    rd_tag   <= tag_mem[rd_index];
    rd_data  <= data_mem[rd_index];
  end

endmodule

/* verilog/request_decode.sv */
`include "cache_params.svh"

module request_decode
  import cache_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   cpu_read_req,
  input  addr_t  cpu_read_addr,
  input  logic   cpu_write_req,
  input  addr_t  cpu_write_addr,
  input  data_t  cpu_write_data,
  input  logic   inv_req,
  input  addr_t  inv_addr,
  input  logic   gets_req,
  input  addr_t  gets_addr,
  input  logic   op_done,
  output logic   op_valid,
  output op_e    op,
  output addr_t  op_addr,
  output index_t op_index,
  output tag_t   op_tag,
  output data_t  op_wdata,
  output index_t rd_index
);

  logic  busy;     // one transaction at a time
  op_e   mask_op;  // source acked this cycle, its req is still up
  op_e   sel_op;
  addr_t sel_addr;

  // fixed priority, directory before cpu
  always_comb begin
    sel_op   = op_none;
    sel_addr = cpu_read_addr;
    if (inv_req && (mask_op != op_dir_inv)) begin
      sel_op   = op_dir_inv;
      sel_addr = inv_addr;
    end else if (gets_req && (mask_op != op_dir_gets)) begin
      sel_op   = op_dir_gets;
      sel_addr = gets_addr;
    end else if (cpu_write_req && (mask_op != op_cpu_write)) begin
      sel_op   = op_cpu_write;
      sel_addr = cpu_write_addr;
    end else if (cpu_read_req && (mask_op != op_cpu_read)) begin
      sel_op   = op_cpu_read;
    end
  end

  // control, busy until execute reports done
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      op_valid <= 1'b0;
      op       <= op_none;
      mask_op  <= op_none;
    end else begin
      op_valid <= 1'b0;              // single cycle strobe
      mask_op  <= op_none;
      if (op_done) begin
        busy    <= 1'b0;
        mask_op <= op;               // hide the acked source for one cycle
      end else if (!busy && (sel_op != op_none)) begin
        busy     <= 1'b1;
        op_valid <= 1'b1;
        op       <= sel_op;
      end
    end
  end

  // payload capture, address split into tag and index
  always_ff @(posedge clk) begin
    if (!busy && (sel_op != op_none)) begin
      op_addr  <= sel_addr;
      op_tag   <= sel_addr[`ADDR_WIDTH-1 -: `TAG_WIDTH];
      op_index <= sel_addr[`INDEX_WIDTH-1:0];
      op_wdata <= cpu_write_data;    // only meaningful for writes
    end
  end

  assign rd_index = op_index;        // store lookup in the op_valid cycle

endmodule

/* verilog/cache_pkg.sv */
`include "cache_params.svh"

package cache_pkg;

  // ---------------------------------------------------------------------------
  // vector types
  // ---------------------------------------------------------------------------
  typedef logic [`ADDR_WIDTH-1:0]  addr_t;  // full address
  typedef logic [`DATA_WIDTH-1:0]  data_t;  // line payload
  typedef logic [`TAG_WIDTH-1:0]   tag_t;   // upper address bits
  typedef logic [`INDEX_WIDTH-1:0] index_t; // line select

  // ---------------------------------------------------------------------------
  // line state, same code is kept in the store
  // ---------------------------------------------------------------------------
  typedef enum logic [2:0] {
    line_i = 3'b000, // invalid
    line_s = 3'b001, // shared, clean
    line_e = 3'b010, // exclusive, clean
    line_o = 3'b011, // owned, dirty and shared
    line_m = 3'b100  // modified, dirty and private
  } moesi_e;

  // kind of the transaction in flight
  typedef enum logic [2:0] {
    op_none      = 3'd0,
    op_cpu_read  = 3'd1,
    op_cpu_write = 3'd2,
    op_dir_inv   = 3'd3, // directory invalidate
    op_dir_gets  = 3'd4  // directory get-shared
  } op_e;

endpackage

/* verilog/cache_params.svh */
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// ---------------------------------------------------------------------------
// cache geometry, direct mapped
// ---------------------------------------------------------------------------

`define CACHE_LINES 128 // lines in the array

`define ADDR_WIDTH  9   // cpu and directory address
`define DATA_WIDTH  8   // one byte per line

// address split, tag on top of index
`define TAG_WIDTH   2   // addr[8:7]
`define INDEX_WIDTH 7   // addr[6:0]

`endif
